//--- hw/makehint_pkg.sv
// Shared coefficient and hint entry types plus default sizes, imported by every hint path module
package makehint_pkg;

  // Width of one coefficient of r and of z
  localparam int COEF_W = 12;

  // Number of low bits dropped to form the high part of a coefficient
  localparam int HB_SHIFT = 8;

  // A polynomial has 256 coefficients, so an index needs 8 bits
  localparam int IDX_W = 8;

  // Up to 8 polynomials per signature
  localparam int POLY_W = 3;

  // Enough bits to count a hint on every coefficient of every polynomial
  localparam int CNT_W = IDX_W + POLY_W + 1;

  // Defaults the top level hands down to the stages
  localparam int NUM_LANES_DEF = 4;
  localparam int NUM_RD_DEF = 3;
  localparam int OMEGA_DEF = 80;

  // One hint as it leaves the engine
  // The pad flag marks filler entries that complete the last output group
  typedef struct packed {
    logic              pad;
    logic [POLY_W-1:0] poly;
    logic [IDX_W-1:0]  idx;
  } hint_entry_t;

  // One lane of input, the coefficient r and the offset z added to it
  typedef struct packed {
    logic [COEF_W-1:0] r;
    logic [COEF_W-1:0] z;
  } coef_pair_t;

endpackage

//--- hw/makehint_hint_calc.sv
// First hint path stage, flags every lane whose high bits change when z is added to r
`timescale 1ns/1ns

module makehint_hint_calc #(
  parameter int NUM_LANES = makehint_pkg::NUM_LANES_DEF,
  parameter int COEF_W = makehint_pkg::COEF_W,
  parameter int HB_SHIFT = makehint_pkg::HB_SHIFT
) (
  input  logic                                    clk,
  input  logic                                    rst_b,
  input  logic                                    zeroize_i,
  input  logic                                    stall_i,

  // Beat from the coefficient source
  input  logic                                    valid_i,
  input  makehint_pkg::coef_pair_t [NUM_LANES-1:0] coef_i,
  input  logic                                    poly_last_i,
  input  logic                                    sig_last_i,

  // Registered hint mask towards the index stage
  output logic                                    valid_o,
  output logic [NUM_LANES-1:0]                    hint_o,
  output logic                                    poly_last_o,
  output logic                                    sig_last_o
);

  // Per lane copies of r and of the wrapped sum, sized by this module
  logic [NUM_LANES-1:0][COEF_W-1:0] r_lane;
  logic [NUM_LANES-1:0][COEF_W-1:0] sum_lane;
  logic [NUM_LANES-1:0]             hint_d;

  always_comb begin
    for (int l = 0; l < NUM_LANES; l++) begin
      r_lane[l] = coef_i[l].r;
      // The add is evaluated at COEF_W bits, so the carry out is lost
      // and the sum wraps modulo 2^COEF_W as the hint rule expects
      sum_lane[l] = coef_i[l].r + coef_i[l].z;
      // A hint is due whenever the high parts disagree
      hint_d[l] = (r_lane[l] >> HB_SHIFT) != (sum_lane[l] >> HB_SHIFT);
    end
  end

  // Beat qualifiers
  // Everything holds while the buffer is full, so a beat waiting here
  // is handed on exactly once after busy drops
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      valid_o     <= 1'b0;
      poly_last_o <= 1'b0;
      sig_last_o  <= 1'b0;
    end else if (zeroize_i) begin
      valid_o     <= 1'b0;
      poly_last_o <= 1'b0;
      sig_last_o  <= 1'b0;
    end else if (!stall_i) begin
      valid_o     <= valid_i;
      // Flags only count when they ride on a real beat
      poly_last_o <= valid_i & poly_last_i;
      sig_last_o  <= valid_i & sig_last_i;
    end
  end

  // Hint mask itself
  // The next stage ignores it unless valid_o is high
  always_ff @(posedge clk) begin
    if (!stall_i) begin
      hint_o <= hint_d;
    end
  end

  // The source has to watch busy from the sample buffer at the far end
  // A beat offered during a stall would overwrite the held one
  no_beat_while_busy_a: assert property (
    @(posedge clk) disable iff (!rst_b || zeroize_i)
    stall_i |-> !valid_i
  );

endmodule

//--- hw/makehint_poly_ctrl.sv
// Second hint path stage, turns hint masks into indexed entries and closes each signature
`timescale 1ns/1ns

module makehint_poly_ctrl #(
  parameter int NUM_LANES = makehint_pkg::NUM_LANES_DEF,
  parameter int NUM_RD = makehint_pkg::NUM_RD_DEF,
  parameter int OMEGA = makehint_pkg::OMEGA_DEF
) (
  input  logic                                     clk,
  input  logic                                     rst_b,
  input  logic                                     zeroize_i,
  input  logic                                     stall_i,
  input  logic                                     valid_i,
  input  logic [NUM_LANES-1:0]                     hint_i,
  input  logic                                     poly_last_i,
  input  logic                                     sig_last_i,
  output logic [NUM_LANES-1:0]                     wr_valid_o,
  output makehint_pkg::hint_entry_t [NUM_LANES-1:0] wr_entry_o,
  output logic                                     done_o,
  output logic [makehint_pkg::CNT_W-1:0]           hint_count_o,
  output logic                                     overflow_o
);
  import makehint_pkg::*;

  // Beats that make up one polynomial of 256 coefficients
  localparam int BEATS = 256 / NUM_LANES;

  logic [IDX_W-1:0]                beat_cnt_q;
  logic [POLY_W-1:0]               poly_cnt_q;
  logic [CNT_W-1:0]                total_q;
  logic                            pad_pending_q;
  logic                            accept;
  logic                            pad_issue;
  logic [NUM_LANES-1:0]            hint_v;
  logic [CNT_W-1:0]                beat_hints;
  logic [CNT_W-1:0]                rem;
  logic [CNT_W-1:0]                pad_cnt;
  logic [NUM_LANES-1:0]            wr_valid_d;
  hint_entry_t [NUM_LANES-1:0]     wr_entry_d;

  // A beat moves on only when the buffer can take what we hold
  assign accept    = valid_i & ~stall_i;
  // The pad beat takes the slot right after the sig_last beat
  assign pad_issue = pad_pending_q & ~stall_i;

  always_comb begin
    hint_v = hint_i & {NUM_LANES{valid_i}};
    beat_hints = '0;
    for (int l = 0; l < NUM_LANES; l++) begin
      beat_hints += CNT_W'(hint_v[l]);
    end
    // Pads needed so the final total lands on a whole output group
    rem = CNT_W'(total_q % NUM_RD);
    pad_cnt = (rem == '0) ? '0 : CNT_W'(NUM_RD) - rem;
  end

  // Build the next write beat
  // Pad entries sit on the low lanes, which needs NUM_RD - 1 <= NUM_LANES
  always_comb begin
    for (int l = 0; l < NUM_LANES; l++) begin
      wr_entry_d[l] = '0;
      if (pad_pending_q) begin
        wr_valid_d[l] = CNT_W'(l) < pad_cnt;
        wr_entry_d[l].pad = 1'b1;
      end else begin
        wr_valid_d[l] = hint_v[l];
        wr_entry_d[l].poly = poly_cnt_q;
        wr_entry_d[l].idx = IDX_W'(int'(beat_cnt_q) * NUM_LANES + l);
      end
    end
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      beat_cnt_q    <= '0;
      poly_cnt_q    <= '0;
      total_q       <= '0;
      pad_pending_q <= 1'b0;
      wr_valid_o    <= '0;
      done_o        <= 1'b0;
      hint_count_o  <= '0;
      overflow_o    <= 1'b0;
    end else if (zeroize_i) begin
      beat_cnt_q    <= '0;
      poly_cnt_q    <= '0;
      total_q       <= '0;
      pad_pending_q <= 1'b0;
      wr_valid_o    <= '0;
      done_o        <= 1'b0;
      hint_count_o  <= '0;
      overflow_o    <= 1'b0;
    end else begin
      // done is a pulse even if the pad beat then waits on a stall
      done_o <= pad_issue;
      if (!stall_i) begin
        wr_valid_o <= wr_valid_d;
      end
      if (pad_issue) begin
        pad_pending_q <= 1'b0;
        total_q       <= '0;
        // Result stays visible until the next signature closes
        hint_count_o  <= total_q;
        overflow_o    <= int'(total_q) > OMEGA;
      end else if (accept) begin
        total_q <= total_q + beat_hints;
        if (sig_last_i) begin
          beat_cnt_q    <= '0;
          poly_cnt_q    <= '0;
          pad_pending_q <= 1'b1;
        end else if (poly_last_i) begin
          beat_cnt_q <= '0;
          poly_cnt_q <= poly_cnt_q + 1'b1;
        end else begin
          beat_cnt_q <= beat_cnt_q + 1'b1;
        end
      end
    end
  end

  // Entry payload follows the write valids
  always_ff @(posedge clk) begin
    if (!stall_i) begin
      wr_entry_o <= wr_entry_d;
    end
  end

  // A polynomial must close on its last beat or indices would run past 255
  poly_len_a: assert property (
    @(posedge clk) disable iff (!rst_b || zeroize_i)
    (accept && beat_cnt_q == IDX_W'(BEATS - 1)) |-> poly_last_i
  );

  // The source leaves one idle cycle after sig_last for the pad beat
  pad_slot_free_a: assert property (
    @(posedge clk) disable iff (!rst_b || zeroize_i)
    pad_pending_q |-> !valid_i
  );

endmodule

//--- hw/makehint_sample_buffer.sv
// Packing buffer that takes up to NUM_WR samples per cycle and hands them out NUM_RD at a time
`timescale 1ns/1ns

module makehint_sample_buffer #(
  parameter int NUM_WR = makehint_pkg::NUM_LANES_DEF,
  parameter int NUM_RD = makehint_pkg::NUM_RD_DEF,
  parameter type sample_t = makehint_pkg::hint_entry_t
) (
  input  logic                    clk,
  input  logic                    rst_b,
  input  logic                    zeroize_i,

  // Write side, any mix of valid lanes
  input  logic [NUM_WR-1:0]       data_valid_i,
  input  sample_t [NUM_WR-1:0]    data_i,
  output logic                    buffer_full_o,

  // Read side, one group of NUM_RD samples per pulse
  output logic                    data_valid_o,
  output sample_t [NUM_RD-1:0]    data_o
);

  localparam int DEPTH = NUM_WR + NUM_RD;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // Slot 0 is the oldest sample
  // Valid bits always form a solid run starting at slot 0
  sample_t [DEPTH-1:0]     buf_q;
  sample_t [DEPTH-1:0]     buf_d;
  logic [DEPTH-1:0]        buf_valid_q;
  logic [DEPTH-1:0]        buf_valid_d;

  // Incoming samples with the gaps squeezed out
  sample_t [NUM_WR-1:0]    wr_pack;
  logic [CNT_W-1:0]        wr_cnt;
  logic [CNT_W-1:0]        wr_base;
  logic [CNT_W-1:0]        num_valid;
  logic                    buf_rd;
  logic                    buf_wr;

  // Full means a whole NUM_WR write could no longer be placed
  // That is the case once fewer than NUM_WR - NUM_RD slots are free
  // When reads keep up with writes the buffer can never fill
  if (NUM_WR > NUM_RD) begin : g_full
    assign buffer_full_o = buf_valid_q[DEPTH-(NUM_WR-NUM_RD)];
  end else begin : g_no_full
    assign buffer_full_o = 1'b0;
  end

  // A group leaves as soon as NUM_RD samples are present
  assign buf_rd = buf_valid_q[NUM_RD-1];
  assign buf_wr = (|data_valid_i) & ~buffer_full_o;

  always_comb begin
    num_valid = '0;
    for (int i = 0; i < DEPTH; i++) begin
      num_valid += CNT_W'(buf_valid_q[i]);
    end
  end

  // Compact the valid lanes into the low end of wr_pack
  always_comb begin
    wr_pack = '0;
    wr_cnt = '0;
    for (int j = 0; j < NUM_WR; j++) begin
      if (data_valid_i[j]) begin
        wr_pack[wr_cnt] = data_i[j];
        wr_cnt += 1'b1;
      end
    end
  end

  // Drop the group that is read and append the new samples behind the rest
  always_comb begin
    wr_base = buf_rd ? num_valid - CNT_W'(NUM_RD) : num_valid;
    buf_d = buf_rd ? (buf_q >> (NUM_RD * $bits(sample_t))) : buf_q;
    buf_valid_d = buf_rd ? (buf_valid_q >> NUM_RD) : buf_valid_q;
    if (buf_wr) begin
      for (int j = 0; j < NUM_WR; j++) begin
        if (CNT_W'(j) < wr_cnt) begin
          buf_d[wr_base + CNT_W'(j)] = wr_pack[j];
          buf_valid_d[wr_base + CNT_W'(j)] = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      buf_valid_q <= '0;
    end else if (zeroize_i) begin
      buf_valid_q <= '0;
    end else if (buf_rd | buf_wr) begin
      buf_valid_q <= buf_valid_d;
    end
  end

  // Sample storage, wiped on zeroize so no hint data survives it
  always_ff @(posedge clk) begin
    if (zeroize_i) begin
      buf_q <= '0;
    end else if (buf_rd | buf_wr) begin
      buf_q <= buf_d;
    end
  end

  // The group in the bottom slots goes straight out
  assign data_valid_o = buf_rd & ~zeroize_i;
  assign data_o = buf_q[NUM_RD-1:0];

  // While full only a read may happen, so the fill drops by one group
  full_blocks_write_a: assert property (
    @(posedge clk) disable iff (!rst_b || zeroize_i)
    buffer_full_o |=> int'(num_valid) == int'($past(num_valid)) - NUM_RD
  );

endmodule

//--- hw/makehint_top.sv
// Top level of the MakeHint path, chains hint decision, indexing and the output packing buffer
`timescale 1ns/1ns

module makehint_top #(
  parameter int NUM_LANES = makehint_pkg::NUM_LANES_DEF,
  parameter int NUM_RD = makehint_pkg::NUM_RD_DEF,
  parameter int OMEGA = makehint_pkg::OMEGA_DEF,
  parameter int COEF_W = makehint_pkg::COEF_W,
  parameter int HB_SHIFT = makehint_pkg::HB_SHIFT
) (
  input  logic                                     clk,
  input  logic                                     rst_b,
  input  logic                                     zeroize_i,

  // Coefficient beats
  input  logic                                     coef_valid_i,
  input  makehint_pkg::coef_pair_t [NUM_LANES-1:0] coef_i,
  input  logic                                     poly_last_i,
  input  logic                                     sig_last_i,
  output logic                                     busy_o,

  // Hint entries, NUM_RD per pulse
  output logic                                     entry_valid_o,
  output makehint_pkg::hint_entry_t [NUM_RD-1:0]   entry_o,

  // Signature summary
  output logic                                     done_o,
  output logic [makehint_pkg::CNT_W-1:0]           hint_count_o,
  output logic                                     overflow_o
);
  import makehint_pkg::*;

  // Hint stage to index stage
  logic                        calc_valid;
  logic [NUM_LANES-1:0]        calc_hint;
  logic                        calc_poly_last;
  logic                        calc_sig_last;

  // Index stage to buffer
  logic [NUM_LANES-1:0]        wr_valid;
  hint_entry_t [NUM_LANES-1:0] wr_entry;

  makehint_hint_calc #(
    .NUM_LANES (NUM_LANES),
    .COEF_W    (COEF_W),
    .HB_SHIFT  (HB_SHIFT)
  ) u_hint_calc (
    .clk         (clk),
    .rst_b       (rst_b),
    .zeroize_i   (zeroize_i),
    .stall_i     (busy_o),
    .valid_i     (coef_valid_i),
    .coef_i      (coef_i),
    .poly_last_i (poly_last_i),
    .sig_last_i  (sig_last_i),
    .valid_o     (calc_valid),
    .hint_o      (calc_hint),
    .poly_last_o (calc_poly_last),
    .sig_last_o  (calc_sig_last)
  );

  makehint_poly_ctrl #(
    .NUM_LANES (NUM_LANES),
    .NUM_RD    (NUM_RD),
    .OMEGA     (OMEGA)
  ) u_poly_ctrl (
    .clk          (clk),
    .rst_b        (rst_b),
    .zeroize_i    (zeroize_i),
    .stall_i      (busy_o),
    .valid_i      (calc_valid),
    .hint_i       (calc_hint),
    .poly_last_i  (calc_poly_last),
    .sig_last_i   (calc_sig_last),
    .wr_valid_o   (wr_valid),
    .wr_entry_o   (wr_entry),
    .done_o       (done_o),
    .hint_count_o (hint_count_o),
    .overflow_o   (overflow_o)
  );

  // The buffer full flag is the busy seen by the source and both stages
  makehint_sample_buffer #(
    .NUM_WR   (NUM_LANES),
    .NUM_RD   (NUM_RD),
    .sample_t (hint_entry_t)
  ) u_sample_buffer (
    .clk           (clk),
    .rst_b         (rst_b),
    .zeroize_i     (zeroize_i),
    .data_valid_i  (wr_valid),
    .data_i        (wr_entry),
    .buffer_full_o (busy_o),
    .data_valid_o  (entry_valid_o),
    .data_o        (entry_o)
  );

endmodule

//--- sim/makehint_tb.sv
// Self-checking testbench for makehint_top, drives LFSR beats and compares against a hint model
`timescale 1ns/1ns

module makehint_tb;
  import makehint_pkg::*;

  localparam int NUM_LANES = NUM_LANES_DEF;
  localparam int NUM_RD = NUM_RD_DEF;
  localparam int OMEGA = OMEGA_DEF;
  localparam int BEATS = 256 / NUM_LANES;
  localparam int WAIT_LIMIT = 2000;

  // How z is drawn for a signature
  localparam int MODE_SPARSE = 0;
  localparam int MODE_DENSE = 1;
  localparam int MODE_MIXED = 2;

  logic                           clk;
  logic                           rst_b;
  logic                           zeroize_i;
  logic                           coef_valid_i;
  coef_pair_t [NUM_LANES-1:0]     coef_i;
  logic                           poly_last_i;
  logic                           sig_last_i;
  logic                           busy_o;
  logic                           entry_valid_o;
  hint_entry_t [NUM_RD-1:0]       entry_o;
  logic                           done_o;
  logic [CNT_W-1:0]               hint_count_o;
  logic                           overflow_o;

  // Model state shared by the stimulus and the output monitor
  logic [31:0]  lfsr_state;
  hint_entry_t  exp_q[$];
  int           exp_total;
  int           exp_done_total;
  int           emitted;
  int           done_seen;
  int           busy_cycles;
  string        test_name;

  makehint_top #(
    .NUM_LANES (NUM_LANES),
    .NUM_RD    (NUM_RD),
    .OMEGA     (OMEGA),
    .COEF_W    (COEF_W),
    .HB_SHIFT  (HB_SHIFT)
  ) DUT (
    .clk           (clk),
    .rst_b         (rst_b),
    .zeroize_i     (zeroize_i),
    .coef_valid_i  (coef_valid_i),
    .coef_i        (coef_i),
    .poly_last_i   (poly_last_i),
    .sig_last_i    (sig_last_i),
    .busy_o        (busy_o),
    .entry_valid_o (entry_valid_o),
    .entry_o       (entry_o),
    .done_o        (done_o),
    .hint_count_o  (hint_count_o),
    .overflow_o    (overflow_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      report_failure($sformatf("CHECK FAILED %s %s: expected 0x%0h, actual 0x%0h",
                               test_name, what, expected, actual));
    end
  endtask

  // Fibonacci LFSR on x^32 + x^22 + x^2 + x + 1, one step per bit handed out
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      val = {val[30:0], fb};
    end
    return val;
  endfunction

  // Dense offsets push r+z at least one high step away without wrapping back
  function automatic int pick_z(input int mode);
    if (mode == MODE_SPARSE) begin
      return 0;
    end else if (mode == MODE_DENSE) begin
      return (1 << HB_SHIFT) + int'(take_bits(COEF_W - 1));
    end
    return int'(take_bits(HB_SHIFT));
  endfunction

  // Hint rule, high part of r against high part of the wrapped sum
  function automatic bit expect_hint(input int r, input int z);
    int sum;
    sum = (r + z) % (1 << COEF_W);
    return (r >> HB_SHIFT) != (sum >> HB_SHIFT);
  endfunction

  task automatic idle_cycle();
    @(posedge clk);
    #1;
    coef_valid_i = 1'b0;
    poly_last_i  = 1'b0;
    sig_last_i   = 1'b0;
  endtask

  // Waits out busy, then drives one beat and records the hints it should produce
  task automatic send_beat(input int mode, input int beat, input int poly,
                           input bit is_poly_last, input bit is_sig_last);
    int          waited;
    int          r_val;
    int          z_val;
    hint_entry_t e;
    waited = 0;
    idle_cycle();
    while (busy_o) begin
      waited++;
      if (waited > WAIT_LIMIT) begin
        report_failure("busy_o stayed high and the pending beat could not be sent");
      end
      idle_cycle();
    end
    for (int l = 0; l < NUM_LANES; l++) begin
      r_val = int'(take_bits(COEF_W));
      z_val = pick_z(mode);
      coef_i[l].r = COEF_W'(r_val);
      coef_i[l].z = COEF_W'(z_val);
      if (expect_hint(r_val, z_val)) begin
        e = '0;
        e.poly = POLY_W'(poly);
        e.idx = IDX_W'(beat * NUM_LANES + l);
        exp_q.push_back(e);
        exp_total++;
      end
    end
    coef_valid_i = 1'b1;
    poly_last_i  = is_poly_last;
    sig_last_i   = is_sig_last;
  endtask

  task automatic wait_for_done();
    int waited;
    waited = 0;
    while (done_seen == 0) begin
      if (waited >= WAIT_LIMIT) begin
        report_failure("done_o never pulsed after the last beat of the signature");
      end
      idle_cycle();
      waited++;
    end
  endtask

  task automatic wait_for_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      if (waited >= WAIT_LIMIT) begin
        report_failure("expected hint entries never left the sample buffer");
      end
      idle_cycle();
      waited++;
    end
  endtask

  // One whole signature, then the padding and summary checks
  task automatic run_signature(input int num_polys, input int mode, input bit gaps);
    int          pads;
    hint_entry_t pad_e;
    exp_total = 0;
    emitted   = 0;
    done_seen = 0;
    for (int p = 0; p < num_polys; p++) begin
      for (int b = 0; b < BEATS; b++) begin
        // Roughly one cycle in eight stays idle when gaps are on
        if (gaps) begin
          while (take_bits(3) == 0) begin
            idle_cycle();
          end
        end
        send_beat(mode, b, p, b == BEATS - 1, (b == BEATS - 1) && (p == num_polys - 1));
      end
    end
    // Filler entries complete the last output group
    // They sit at the tail of the queue, so the monitor sees them last
    pads = (NUM_RD - exp_total % NUM_RD) % NUM_RD;
    for (int i = 0; i < pads; i++) begin
      pad_e = '0;
      pad_e.pad = 1'b1;
      exp_q.push_back(pad_e);
    end
    exp_done_total = exp_total;
    wait_for_done();
    wait_for_drain();
    repeat (8) idle_cycle();
    check_value("done pulses", 1, done_seen);
    check_value("held hint count", exp_done_total, 32'(hint_count_o));
    check_value("held overflow", exp_done_total > OMEGA, 32'(overflow_o));
  endtask

  // Part of a signature, then zeroize while hints are still in the pipeline
  task automatic zeroize_midway();
    exp_total = 0;
    for (int b = 0; b < 20; b++) begin
      send_beat(MODE_DENSE, b, 0, 1'b0, 1'b0);
    end
    @(posedge clk);
    #1;
    coef_valid_i = 1'b0;
    zeroize_i = 1'b1;
    exp_q.delete();
    exp_total = 0;
    @(posedge clk);
    #1;
    zeroize_i = 1'b0;
    @(negedge clk);
    check_value("entry_valid_o after zeroize", 0, 32'(entry_valid_o));
    check_value("done_o after zeroize", 0, 32'(done_o));
    check_value("busy_o after zeroize", 0, 32'(busy_o));
    repeat (8) idle_cycle();
  endtask

  // Output monitor, sampled mid cycle where every output is settled
  always @(negedge clk) begin
    hint_entry_t exp_e;
    if (rst_b) begin
      if (busy_o) begin
        busy_cycles++;
      end
      if (entry_valid_o) begin
        for (int i = 0; i < NUM_RD; i++) begin
          if (exp_q.size() == 0) begin
            report_failure($sformatf("%s: an entry group came out with no entry expected",
                                     test_name));
          end
          exp_e = exp_q.pop_front();
          check_value($sformatf("entry %0d", emitted), 32'(exp_e), 32'(entry_o[i]));
          emitted++;
        end
      end
      if (done_o) begin
        done_seen++;
        check_value("hint count at done", exp_done_total, 32'(hint_count_o));
        check_value("overflow at done", exp_done_total > OMEGA, 32'(overflow_o));
      end
    end
  end

  initial begin
    rst_b        = 1'b0;
    zeroize_i    = 1'b0;
    coef_valid_i = 1'b0;
    coef_i       = '0;
    poly_last_i  = 1'b0;
    sig_last_i   = 1'b0;
    lfsr_state   = 32'ha508b8b7;
    exp_total    = 0;
    exp_done_total = 0;
    emitted      = 0;
    done_seen    = 0;
    busy_cycles  = 0;
    test_name    = "reset";

    repeat (8) @(posedge clk);
    #1;
    rst_b = 1'b1;
    @(negedge clk);
    check_value("entry_valid_o", 0, 32'(entry_valid_o));
    check_value("done_o", 0, 32'(done_o));
    check_value("busy_o", 0, 32'(busy_o));

    // Mixed offsets give roughly half the lanes a hint
    test_name = "random hints";
    run_signature(3, MODE_MIXED, 1'b1);

    test_name = "dense overflow";
    run_signature(2, MODE_DENSE, 1'b0);
    check_value("overflow_o", 1, 32'(overflow_o));

    test_name = "sparse";
    run_signature(1, MODE_SPARSE, 1'b0);
    check_value("overflow_o", 0, 32'(overflow_o));
    check_value("hint_count_o", 0, 32'(hint_count_o));

    // Dense beats on random cycles write faster than the buffer drains
    test_name = "back-pressure";
    busy_cycles = 0;
    run_signature(2, MODE_DENSE, 1'b1);
    if (busy_cycles == 0) begin
      report_failure("back-pressure: busy_o never went high under dense traffic");
    end

    test_name = "zeroize";
    zeroize_midway();
    test_name = "after zeroize";
    run_signature(1, MODE_MIXED, 1'b1);

    $display("sim passed");
    $finish;
  end

endmodule

//--- verilog.f
hw/makehint_pkg.sv
hw/makehint_hint_calc.sv
hw/makehint_poly_ctrl.sv
hw/makehint_sample_buffer.sv
hw/makehint_top.sv
sim/makehint_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the MakeHint testbench with Verilator, runs it and scans the log for the verdict
set -e

cd "$(dirname "$0")"

LOG=sim.log
MDIR=obj_dir

rm -rf "$MDIR" "$LOG"

verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module makehint_tb \
  --Mdir "$MDIR" -o Vmakehint_tb \
  -f verilog.f

"./$MDIR/Vmakehint_tb" 2>&1 | tee "$LOG"

if grep -q "sim failed" "$LOG"; then
  echo "Simulation reported a failure, see $LOG"
  exit 1
fi

if ! grep -q "sim passed" "$LOG"; then
  echo "Simulation ended without a verdict, see $LOG"
  exit 1
fi
